/* lq_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_lq_params.svh"

module lq_dispatch import lsu_lq_pkg::*; (
    input  lq_alloc_t            i_alloc,
    input  lq_update_t           i_update,
    input  lq_fill_t             i_fill,
    input  logic [`LQ_DEPTH-1:0] i_empty_vec,
    output logic [`LQ_DEPTH-1:0] o_alloc_select_vec,
    output logic                 o_full,
    output lq_state_t            o_update_state
);

    logic fill_tag_hit;

    // Isolate the lowest set bit of the empty vector and gate it with the request
    assign o_alloc_select_vec = {`LQ_DEPTH{i_alloc.en}} &
                                (i_empty_vec & ~(i_empty_vec - `LQ_DEPTH'(1)));

    // Full means no free entry is left once this cycle's allocation lands
    assign o_full = ((i_empty_vec & ~o_alloc_select_vec) == '0);

    // A fill in the same cycle as the update can wake the load right away
    assign fill_tag_hit = i_fill.en && (i_update.mhq_tag == i_fill.tag);

    // One decode serves every entry, each entry only uses it when selected
    always_comb begin
        if (!i_update.retry) begin
            o_update_state = LQ_STATE_COMPLETE;
        end else if (i_update.replay || i_update.mhq_replay) begin
            // Conflict with a fill in flight, so just go again
            o_update_state = LQ_STATE_REPLAYABLE;
        end else if (i_update.mhq_retry) begin
            // MHQ was full, any fill may free the line we need
            o_update_state = i_fill.en ? LQ_STATE_REPLAYABLE : LQ_STATE_MHQ_FILL_WAIT;
        end else begin
            o_update_state = fill_tag_hit ? LQ_STATE_REPLAYABLE : LQ_STATE_MHQ_TAG_WAIT;
        end
    end

    // Allocation never picks two slots or one that is already in use
    always_comb begin
        assert ($onehot0(o_alloc_select_vec) && ((o_alloc_select_vec & ~i_empty_vec) == '0))
            else $error("lq_dispatch: bad allocation select %b", o_alloc_select_vec);
    end

endmodule

`default_nettype wire

/* lq_drain.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_lq_params.svh"

module lq_drain import lsu_lq_pkg::*; (
    input  logic                         clk,
    input  logic                         n_rst,
    input  logic                         i_flush,
    input  logic                         i_replay_stall,
    input  logic [`LQ_DEPTH-1:0]         i_replayable_vec,
    input  logic [`LQ_DEPTH-1:0]         i_retire_hit_vec,
    input  logic [`LQ_DEPTH-1:0]         i_misspec_vec,
    input  lsu_func_t                    i_func_arr [`LQ_DEPTH],
    input  logic [`LQ_ADDR_WIDTH-1:0]    i_addr_arr [`LQ_DEPTH],
    input  logic [`LQ_ROB_TAG_WIDTH-1:0] i_tag_arr  [`LQ_DEPTH],
    output logic [`LQ_DEPTH-1:0]         o_replay_select_vec,
    output lq_replay_t                   o_replay,
    output logic                         o_retire_ack,
    output logic                         o_retire_misspec
);

    lq_replay_t replay_pick;
    logic       retire_any;
    logic       retire_misspec;

    // Lowest replayable entry wins, nothing is picked while the pipe is stalled
    always_comb begin
        replay_pick = '0;
        if (!i_replay_stall) begin
            replay_pick.select = i_replayable_vec & ~(i_replayable_vec - `LQ_DEPTH'(1));
        end
        replay_pick.en = |replay_pick.select;

        // Select is one-hot, so at most one slot drives the fields
        for (int i = 0; i < `LQ_DEPTH; i++) begin
            if (replay_pick.select[i]) begin
                replay_pick.func = i_func_arr[i];
                replay_pick.addr = i_addr_arr[i];
                replay_pick.tag  = i_tag_arr[i];
            end
        end
    end

    // Winner moves to LAUNCHED at the same edge its replay goes out
    assign o_replay_select_vec = replay_pick.select;

    // Retire hits are one-hot, so an AND-OR is enough for the misspec mux
    assign retire_any     = |i_retire_hit_vec;
    assign retire_misspec = |(i_retire_hit_vec & i_misspec_vec);

    // Replay output holds its value for as long as the stall lasts
    always_ff @(posedge clk) begin
        if (!n_rst || i_flush) begin
            o_replay.en <= 1'b0;
        end else if (!i_replay_stall) begin
            o_replay.en <= replay_pick.en;
        end
        if (!i_replay_stall) begin
            o_replay.select <= replay_pick.select;
            o_replay.func   <= replay_pick.func;
            o_replay.addr   <= replay_pick.addr;
            o_replay.tag    <= replay_pick.tag;
        end
    end

    // Acknowledge goes back to the ROB one cycle after the request
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_retire_ack <= 1'b0;
        end else begin
            o_retire_ack <= retire_any;
        end
    end

    // Misspec bit travels alongside the acknowledge
    always_ff @(posedge clk) begin
        o_retire_misspec <= retire_misspec;
    end

    // Unique ROB tags mean no two entries may answer the same retire
    assert property (@(posedge clk) disable iff (!n_rst) $onehot0(i_retire_hit_vec))
        else $error("lq_drain: several entries hit one retire, %b", i_retire_hit_vec);

endmodule

`default_nettype wire

/* lq_entry.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_lq_params.svh"

module lq_entry import lsu_lq_pkg::*; #(
    parameter int ENTRY_IDX = 0
) (
    input  logic                         clk,
    input  logic                         n_rst,
    input  logic                         i_flush,
    input  lq_alloc_t                    i_alloc,
    input  logic                         i_alloc_sel,
    input  lq_update_t                   i_update,
    input  lq_state_t                    i_update_state,
    input  lq_fill_t                     i_fill,
    input  lq_store_t                    i_store,
    input  logic                         i_replay_sel,
    input  logic                         i_retire_en,
    input  logic [`LQ_ROB_TAG_WIDTH-1:0] i_retire_tag,
    output logic                         o_empty,
    output logic                         o_replayable,
    output logic                         o_retire_hit,
    output logic                         o_misspec,
    output lsu_func_t                    o_func,
    output logic [`LQ_ADDR_WIDTH-1:0]    o_addr,
    output logic [`LQ_ROB_TAG_WIDTH-1:0] o_tag
);

    lq_state_t                    state_q;
    lq_state_t                    state_next;
    lsu_func_t                    func_q;
    logic [`LQ_ADDR_WIDTH-1:0]    addr_q;
    logic [`LQ_ROB_TAG_WIDTH-1:0] tag_q;
    logic [`LQ_MHQ_TAG_WIDTH-1:0] mhq_tag_q;
    logic                         misspec_q;
    logic                         update_hit;
    logic                         fill_tag_hit;
    logic                         store_hit;
    logic                         misspec_clear;
    logic [`LQ_ADDR_WIDTH-1:0]    load_end;
    logic [`LQ_ADDR_WIDTH-1:0]    store_end;

    // This slot's bit of the one-hot update select
    assign update_hit   = i_update.en && i_update.select[ENTRY_IDX];

    // Wake-up for a load parked on one MHQ tag
    assign fill_tag_hit = i_fill.en && (mhq_tag_q == i_fill.tag);

    assign o_empty      = (state_q == LQ_STATE_INVALID);
    assign o_replayable = (state_q == LQ_STATE_REPLAYABLE);

    // ROB tags are unique, so only a finished load with the same tag can retire
    assign o_retire_hit = i_retire_en && (state_q == LQ_STATE_COMPLETE) &&
                          (tag_q == i_retire_tag);

    assign o_misspec    = misspec_q;
    assign o_func       = func_q;
    assign o_addr       = addr_q;
    assign o_tag        = tag_q;

    // Byte ranges are half open, end is one past the last byte
    assign load_end  = addr_q + `LQ_ADDR_WIDTH'(lsu_access_bytes(func_q));
    assign store_end = i_store.addr + `LQ_ADDR_WIDTH'(lsu_access_bytes(i_store.func));

    // Two ranges overlap when each one starts before the other ends
    assign store_hit = i_store.en && !o_empty &&
                       (addr_q < store_end) && (i_store.addr < load_end);

    // A load that still has to run again cannot have passed on stale data
    assign misspec_clear = i_alloc_sel ||
                           (state_q == LQ_STATE_MHQ_TAG_WAIT) ||
                           (state_q == LQ_STATE_MHQ_FILL_WAIT) ||
                           (state_q == LQ_STATE_REPLAYABLE);

    // The select inputs were already qualified upstream and are trusted as is
    always_comb begin
        state_next = state_q;
        case (state_q)
            LQ_STATE_INVALID: begin
                if (i_alloc_sel) begin
                    state_next = LQ_STATE_VALID;
                end
            end
            LQ_STATE_VALID, LQ_STATE_LAUNCHED: begin
                // Both in the pipeline and waiting for the execute result
                if (update_hit) begin
                    state_next = i_update_state;
                end
            end
            LQ_STATE_MHQ_TAG_WAIT: begin
                if (fill_tag_hit) begin
                    state_next = LQ_STATE_REPLAYABLE;
                end
            end
            LQ_STATE_MHQ_FILL_WAIT: begin
                if (i_fill.en) begin
                    state_next = LQ_STATE_REPLAYABLE;
                end
            end
            LQ_STATE_REPLAYABLE: begin
                if (i_replay_sel) begin
                    state_next = LQ_STATE_LAUNCHED;
                end
            end
            LQ_STATE_COMPLETE: begin
                if (o_retire_hit) begin
                    state_next = LQ_STATE_INVALID;
                end
            end
            default: begin
                state_next = LQ_STATE_INVALID;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!n_rst || i_flush) begin
            state_q <= LQ_STATE_INVALID;
        end else begin
            state_q <= state_next;
        end
    end

    // Load fields are captured once when the slot is taken
    always_ff @(posedge clk) begin
        if (i_alloc_sel) begin
            func_q <= i_alloc.func;
            addr_q <= i_alloc.addr;
            tag_q  <= i_alloc.tag;
        end
        if (update_hit) begin
            mhq_tag_q <= i_update.mhq_tag;
        end
        misspec_q <= !misspec_clear && (store_hit || misspec_q);
    end

    // Encoding 3'b111 has no state behind it
    assert property (@(posedge clk) disable iff (!n_rst) state_q != 3'b111)
        else $error("lq_entry %0d: unused state encoding", ENTRY_IDX);

endmodule

`default_nettype wire

/* lsu_lq.f */
+incdir+.
lsu_lq_pkg.sv
lq_dispatch.sv
lq_entry.sv
lq_drain.sv
lsu_lq.sv
tb_lsu_lq.sv

/* lsu_lq.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_lq_params.svh"

module lsu_lq import lsu_lq_pkg::*; (
    input  logic                         clk,
    input  logic                         n_rst,
    input  logic                         i_flush,
    input  lq_alloc_t                    i_alloc,
    input  lq_update_t                   i_update,
    input  lq_fill_t                     i_fill,
    input  lq_store_t                    i_store,
    input  logic                         i_replay_stall,
    input  logic                         i_retire_en,
    input  logic [`LQ_ROB_TAG_WIDTH-1:0] i_retire_tag,
    output logic                         o_full,
    output logic [`LQ_DEPTH-1:0]         o_alloc_select,
    output lq_replay_t                   o_replay,
    output logic                         o_retire_ack,
    output logic                         o_retire_misspec
);

    logic [`LQ_DEPTH-1:0]         empty_vec;
    logic [`LQ_DEPTH-1:0]         replayable_vec;
    logic [`LQ_DEPTH-1:0]         retire_hit_vec;
    logic [`LQ_DEPTH-1:0]         misspec_vec;
    logic [`LQ_DEPTH-1:0]         alloc_select_vec;
    logic [`LQ_DEPTH-1:0]         replay_select_vec;
    lq_state_t                    update_state;
    lsu_func_t                    func_arr [`LQ_DEPTH];
    logic [`LQ_ADDR_WIDTH-1:0]    addr_arr [`LQ_DEPTH];
    logic [`LQ_ROB_TAG_WIDTH-1:0] tag_arr  [`LQ_DEPTH];

    // Slot choice, full flag and execute result decode
    lq_dispatch u_dispatch (
        .i_alloc            (i_alloc),
        .i_update           (i_update),
        .i_fill             (i_fill),
        .i_empty_vec        (empty_vec),
        .o_alloc_select_vec (alloc_select_vec),
        .o_full             (o_full),
        .o_update_state     (update_state)
    );

    // The chosen slot is reported to the issue side a cycle later
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_alloc_select <= '0;
        end else begin
            o_alloc_select <= alloc_select_vec;
        end
    end

    for (genvar i = 0; i < `LQ_DEPTH; i++) begin : g_entry
        lq_entry #(
            .ENTRY_IDX (i)
        ) u_entry (
            .clk            (clk),
            .n_rst          (n_rst),
            .i_flush        (i_flush),
            .i_alloc        (i_alloc),
            .i_alloc_sel    (alloc_select_vec[i]),
            .i_update       (i_update),
            .i_update_state (update_state),
            .i_fill         (i_fill),
            .i_store        (i_store),
            .i_replay_sel   (replay_select_vec[i]),
            .i_retire_en    (i_retire_en),
            .i_retire_tag   (i_retire_tag),
            .o_empty        (empty_vec[i]),
            .o_replayable   (replayable_vec[i]),
            .o_retire_hit   (retire_hit_vec[i]),
            .o_misspec      (misspec_vec[i]),
            .o_func         (func_arr[i]),
            .o_addr         (addr_arr[i]),
            .o_tag          (tag_arr[i])
        );
    end

    // Replay arbitration and the registered ROB answer
    lq_drain u_drain (
        .clk                 (clk),
        .n_rst               (n_rst),
        .i_flush             (i_flush),
        .i_replay_stall      (i_replay_stall),
        .i_replayable_vec    (replayable_vec),
        .i_retire_hit_vec    (retire_hit_vec),
        .i_misspec_vec       (misspec_vec),
        .i_func_arr          (func_arr),
        .i_addr_arr          (addr_arr),
        .i_tag_arr           (tag_arr),
        .o_replay_select_vec (replay_select_vec),
        .o_replay            (o_replay),
        .o_retire_ack        (o_retire_ack),
        .o_retire_misspec    (o_retire_misspec)
    );

endmodule

`default_nettype wire

/* lsu_lq_params.svh */
`ifndef LSU_LQ_PARAMS_SVH
`define LSU_LQ_PARAMS_SVH

// Sizing of the load queue and of the tags it carries

// Number of load queue entries; 4, 8 and 16 are supported
`define LQ_DEPTH 8

// Width of load and store byte addresses
`define LQ_ADDR_WIDTH 32

// Width of the reorder buffer tag that names each load
`define LQ_ROB_TAG_WIDTH 5

// Width of the miss handling queue tag a missed load waits on
`define LQ_MHQ_TAG_WIDTH 2

// Width of the LSU function code
`define LQ_FUNC_WIDTH 4

// Width of the entry state register
`define LQ_STATE_WIDTH 3

`endif

/* lsu_lq_patterns.txt */
# cmd ALLOC func tag addr full | UPDATE entry flags(retry,replay,mhqretry,mhqreplay) mhqtag
# FILL tag | STORE func addr | STALL lvl | RETIRE tag ack misspec | IDLE chk en tag | FLUSH
ALLOC 2 01 100 0
ALLOC 2 02 200 0
ALLOC 1 03 300 0
ALLOC 0 04 400 0
ALLOC 2 05 500 0
ALLOC 2 06 600 0
ALLOC 2 07 700 0
ALLOC 2 08 800 1
IDLE 0 0 0
UPDATE 0 0 0
UPDATE 1 0 0
RETIRE 09 0 0
RETIRE 03 0 0
STORE 6 102
STORE 7 1fc
RETIRE 01 1 1
RETIRE 02 1 0
ALLOC 2 0a 900 0
UPDATE 2 8 1
UPDATE 3 a 0
FILL 2
IDLE 1 1 04
IDLE 1 0 0
FILL 1
IDLE 1 1 03
IDLE 1 0 0
UPDATE 6 c 0
UPDATE 4 c 0
STALL 1
UPDATE 5 c 0
IDLE 1 1 07
STALL 0
IDLE 1 1 06
IDLE 1 0 0
UPDATE 7 c 0
FLUSH
IDLE 1 0 0
ALLOC 0 11 a00 0
ALLOC 1 12 a10 0
ALLOC 2 13 a20 0
ALLOC 3 14 a30 0
ALLOC 4 15 a40 0
ALLOC 2 16 a50 0
ALLOC 2 17 a60 0
ALLOC 2 18 a70 1
IDLE 0 0 0

/* lsu_lq_pkg.sv */
`default_nettype none

`include "lsu_lq_params.svh"

package lsu_lq_pkg;

    // LSU operation; loads and stores share one encoding space
    typedef enum logic [`LQ_FUNC_WIDTH-1:0] {
        LSU_FUNC_LB  = 4'b0000,
        LSU_FUNC_LH  = 4'b0001,
        LSU_FUNC_LW  = 4'b0010,
        LSU_FUNC_LBU = 4'b0011,
        LSU_FUNC_LHU = 4'b0100,
        LSU_FUNC_SB  = 4'b0101,
        LSU_FUNC_SH  = 4'b0110,
        LSU_FUNC_SW  = 4'b0111
    } lsu_func_t;

    // Life cycle of one load queue entry
    // MHQ_TAG_WAIT waits for the fill of one MHQ tag, MHQ_FILL_WAIT for any fill
    typedef enum logic [`LQ_STATE_WIDTH-1:0] {
        LQ_STATE_INVALID       = 3'b000,
        LQ_STATE_VALID         = 3'b001,
        LQ_STATE_MHQ_TAG_WAIT  = 3'b010,
        LQ_STATE_MHQ_FILL_WAIT = 3'b011,
        LQ_STATE_REPLAYABLE    = 3'b100,
        LQ_STATE_LAUNCHED      = 3'b101,
        LQ_STATE_COMPLETE      = 3'b110
    } lq_state_t;

    // New load issued towards the LSU
    typedef struct packed {
        logic                         en;
        lsu_func_t                    func;
        logic [`LQ_ROB_TAG_WIDTH-1:0] tag;
        logic [`LQ_ADDR_WIDTH-1:0]    addr;
    } lq_alloc_t;

    // Result of the execute stage for one entry
    typedef struct packed {
        logic                         en;
        logic [`LQ_DEPTH-1:0]         select;
        logic                         retry;
        logic                         replay;
        logic                         mhq_retry;
        logic                         mhq_replay;
        logic [`LQ_MHQ_TAG_WIDTH-1:0] mhq_tag;
    } lq_update_t;

    // Fill broadcast from the MHQ
    typedef struct packed {
        logic                         en;
        logic [`LQ_MHQ_TAG_WIDTH-1:0] tag;
    } lq_fill_t;

    // Store leaving the store queue at retirement
    typedef struct packed {
        logic                      en;
        logic [`LQ_ADDR_WIDTH-1:0] addr;
        lsu_func_t                 func;
    } lq_store_t;

    // Load sent back into the LSU pipeline
    typedef struct packed {
        logic                         en;
        logic [`LQ_DEPTH-1:0]         select;
        lsu_func_t                    func;
        logic [`LQ_ADDR_WIDTH-1:0]    addr;
        logic [`LQ_ROB_TAG_WIDTH-1:0] tag;
    } lq_replay_t;

    // Number of bytes touched by an access; word is the fallback
    function automatic logic [2:0] lsu_access_bytes(input lsu_func_t func);
        case (func)
            LSU_FUNC_LB, LSU_FUNC_LBU, LSU_FUNC_SB: return 3'd1;
            LSU_FUNC_LH, LSU_FUNC_LHU, LSU_FUNC_SH: return 3'd2;
            default:                                return 3'd4;
        endcase
    endfunction

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the load queue testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_lsu_lq -f lsu_lq.f -o sim_lsu_lq

out=$(./obj_dir/sim_lsu_lq)
echo "$out"

echo "$out" | grep -q "^TEST PASSED$"

/* tb_lsu_lq.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_lq_params.svh"

module tb_lsu_lq import lsu_lq_pkg::*; ();

    logic                         clk;
    logic                         n_rst;
    logic                         flush;
    lq_alloc_t                    alloc;
    lq_update_t                   upd;
    lq_fill_t                     fill;
    lq_store_t                    store;
    logic                         stall;
    logic                         retire_en;
    logic [`LQ_ROB_TAG_WIDTH-1:0] retire_tag;
    logic                         full;
    logic [`LQ_DEPTH-1:0]         alloc_select;
    lq_replay_t                   replay;
    logic                         retire_ack;
    logic                         retire_misspec;

    // Reference model of every entry
    lq_state_t                    m_state [`LQ_DEPTH];
    lsu_func_t                    m_func  [`LQ_DEPTH];
    logic [`LQ_ADDR_WIDTH-1:0]    m_addr  [`LQ_DEPTH];
    logic [`LQ_ROB_TAG_WIDTH-1:0] m_tag   [`LQ_DEPTH];
    logic [`LQ_MHQ_TAG_WIDTH-1:0] m_mhq   [`LQ_DEPTH];
    logic                         m_mis   [`LQ_DEPTH];

    // Registered outputs the model predicts for the next edge
    logic                         e_rep_en;
    logic [`LQ_DEPTH-1:0]         e_rep_sel;
    lsu_func_t                    e_rep_func;
    logic [`LQ_ADDR_WIDTH-1:0]    e_rep_addr;
    logic [`LQ_ROB_TAG_WIDTH-1:0] e_rep_tag;
    logic                         e_ack;
    logic                         e_mis;
    logic [`LQ_DEPTH-1:0]         e_alloc_sel;
    logic                         e_full;

    // Expected values taken straight from the pattern file
    logic                         f_chk_rep;
    logic                         f_rep_en;
    logic [31:0]                  f_rep_tag;
    logic                         f_chk_ret;
    logic                         f_ack;
    logic                         f_mis;

    string                        lines [$];
    int                           n_cmds;

    lsu_lq UUT (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_flush          (flush),
        .i_alloc          (alloc),
        .i_update         (upd),
        .i_fill           (fill),
        .i_store          (store),
        .i_replay_stall   (stall),
        .i_retire_en      (retire_en),
        .i_retire_tag     (retire_tag),
        .o_full           (full),
        .o_alloc_select   (alloc_select),
        .o_replay         (replay),
        .o_retire_ack     (retire_ack),
        .o_retire_misspec (retire_misspec)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string msg);
        stop_run($sformatf("error at %0t ns: %s", $time, msg));
    endtask

    // Bytes touched by a load or store of the given function
    function automatic int access_size(input lsu_func_t f);
        case (f)
            LSU_FUNC_LB, LSU_FUNC_LBU, LSU_FUNC_SB: access_size = 1;
            LSU_FUNC_LH, LSU_FUNC_LHU, LSU_FUNC_SH: access_size = 2;
            default:                                access_size = 4;
        endcase
    endfunction

    // Advance the model by one clock using the inputs driven this cycle
    task automatic model_step();
        logic [`LQ_DEPTH-1:0]    free_vec;
        logic [`LQ_DEPTH-1:0]    asel;
        logic [`LQ_DEPTH-1:0]    rsel;
        lq_state_t               upd_state;
        lq_state_t               nxt;
        logic [`LQ_ADDR_WIDTH:0] l_lo;
        logic [`LQ_ADDR_WIDTH:0] l_hi;
        logic [`LQ_ADDR_WIDTH:0] s_lo;
        logic [`LQ_ADDR_WIDTH:0] s_hi;
        logic                    ovl;
        logic                    upd_sel;
        int                      hit;
        int                      n_free;
        free_vec = '0;
        asel     = '0;
        rsel     = '0;
        hit      = -1;
        n_free   = 0;
        for (int i = 0; i < `LQ_DEPTH; i++) begin
            free_vec[i] = (m_state[i] == LQ_STATE_INVALID);
            if (free_vec[i]) n_free++;
        end
        // Lowest free slot first
        for (int i = 0; i < `LQ_DEPTH; i++) begin
            if (alloc.en && free_vec[i] && asel == '0) asel[i] = 1'b1;
        end
        // Full once no slot is free or the last free one is taken right now
        e_full = (n_free == 0) || (alloc.en && n_free == 1);
        for (int i = 0; i < `LQ_DEPTH; i++) begin
            if (!stall && m_state[i] == LQ_STATE_REPLAYABLE && rsel == '0) rsel[i] = 1'b1;
            if (retire_en && m_state[i] == LQ_STATE_COMPLETE && m_tag[i] == retire_tag) hit = i;
        end
        if (!upd.retry) begin
            upd_state = LQ_STATE_COMPLETE;
        end else if (upd.replay || upd.mhq_replay) begin
            upd_state = LQ_STATE_REPLAYABLE;
        end else if (upd.mhq_retry) begin
            upd_state = fill.en ? LQ_STATE_REPLAYABLE : LQ_STATE_MHQ_FILL_WAIT;
        end else begin
            upd_state = (fill.en && fill.tag == upd.mhq_tag) ? LQ_STATE_REPLAYABLE
                                                             : LQ_STATE_MHQ_TAG_WAIT;
        end
        e_alloc_sel = asel;
        e_ack       = (hit >= 0);
        e_mis       = (hit >= 0) ? m_mis[hit] : 1'b0;
        // Replay output is frozen while stalled
        if (!stall) begin
            e_rep_sel = rsel;
            e_rep_en  = (rsel != '0);
            for (int i = 0; i < `LQ_DEPTH; i++) begin
                if (rsel[i]) begin
                    e_rep_func = m_func[i];
                    e_rep_addr = m_addr[i];
                    e_rep_tag  = m_tag[i];
                end
            end
        end
        if (flush) e_rep_en = 1'b0;
        for (int i = 0; i < `LQ_DEPTH; i++) begin
            upd_sel = upd.en && upd.select[i];
            nxt     = m_state[i];
            case (m_state[i])
                LQ_STATE_INVALID:       if (asel[i]) nxt = LQ_STATE_VALID;
                LQ_STATE_VALID,
                LQ_STATE_LAUNCHED:      if (upd_sel) nxt = upd_state;
                LQ_STATE_MHQ_TAG_WAIT:  if (fill.en && fill.tag == m_mhq[i])
                                            nxt = LQ_STATE_REPLAYABLE;
                LQ_STATE_MHQ_FILL_WAIT: if (fill.en) nxt = LQ_STATE_REPLAYABLE;
                LQ_STATE_REPLAYABLE:    if (rsel[i]) nxt = LQ_STATE_LAUNCHED;
                LQ_STATE_COMPLETE:      if (hit == i) nxt = LQ_STATE_INVALID;
                default:                nxt = LQ_STATE_INVALID;
            endcase
            // Byte ranges are half open
            l_lo = {1'b0, m_addr[i]};
            l_hi = l_lo + (`LQ_ADDR_WIDTH+1)'(access_size(m_func[i]));
            s_lo = {1'b0, store.addr};
            s_hi = s_lo + (`LQ_ADDR_WIDTH+1)'(access_size(store.func));
            ovl  = store.en && m_state[i] != LQ_STATE_INVALID && l_lo < s_hi && s_lo < l_hi;
            if (asel[i] || m_state[i] == LQ_STATE_MHQ_TAG_WAIT ||
                m_state[i] == LQ_STATE_MHQ_FILL_WAIT || m_state[i] == LQ_STATE_REPLAYABLE) begin
                m_mis[i] = 1'b0;
            end else if (ovl) begin
                m_mis[i] = 1'b1;
            end
            if (asel[i]) begin
                m_func[i] = alloc.func;
                m_addr[i] = alloc.addr;
                m_tag[i]  = alloc.tag;
            end
            if (upd_sel) m_mhq[i] = upd.mhq_tag;
            m_state[i] = flush ? LQ_STATE_INVALID : nxt;
        end
    endtask

    // Compare registered outputs after the edge against model and file
    task automatic check_outputs();
        assert (alloc_select === e_alloc_sel)
            else report_mismatch($sformatf("alloc select %b, expected %b",
                                           alloc_select, e_alloc_sel));
        assert (replay.en === e_rep_en)
            else report_mismatch($sformatf("replay enable %b, expected %b",
                                           replay.en, e_rep_en));
        if (e_rep_en) begin
            assert (replay.select === e_rep_sel && replay.func === e_rep_func &&
                    replay.addr === e_rep_addr && replay.tag === e_rep_tag)
                else report_mismatch($sformatf("replay tag %h addr %h, expected %h addr %h",
                                               replay.tag, replay.addr, e_rep_tag, e_rep_addr));
        end
        assert (retire_ack === e_ack)
            else report_mismatch($sformatf("retire ack %b, expected %b", retire_ack, e_ack));
        if (e_ack) begin
            assert (retire_misspec === e_mis)
                else report_mismatch($sformatf("retire misspec %b, expected %b",
                                               retire_misspec, e_mis));
        end
        if (f_chk_ret) begin
            assert (retire_ack === f_ack && (!f_ack || retire_misspec === f_mis))
                else report_mismatch($sformatf("retire ack/misspec %b/%b, pattern wants %b/%b",
                                               retire_ack, retire_misspec, f_ack, f_mis));
        end
        if (f_chk_rep) begin
            assert (replay.en === f_rep_en &&
                    (!f_rep_en || replay.tag === f_rep_tag[`LQ_ROB_TAG_WIDTH-1:0]))
                else report_mismatch($sformatf("replay en/tag %b/%h, pattern wants %b/%h",
                                               replay.en, replay.tag, f_rep_en, f_rep_tag));
        end
        f_chk_ret = 1'b0;
        f_chk_rep = 1'b0;
    endtask

    initial begin
        int          fd;
        int          cnt;
        string       line;
        string       cmd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        n_cmds     = 0;
        n_rst      = 1'b0;
        flush      = 1'b0;
        alloc      = '0;
        upd        = '0;
        fill       = '0;
        store      = '0;
        stall      = 1'b0;
        retire_en  = 1'b0;
        retire_tag = '0;
        f_chk_rep  = 1'b0;
        f_chk_ret  = 1'b0;
        f_rep_en   = 1'b0;
        f_rep_tag  = '0;
        f_ack      = 1'b0;
        f_mis      = 1'b0;
        e_rep_en   = 1'b0;
        e_rep_sel  = '0;
        e_ack      = 1'b0;
        e_mis      = 1'b0;
        e_alloc_sel = '0;
        for (int i = 0; i < `LQ_DEPTH; i++) begin
            m_state[i] = LQ_STATE_INVALID;
            m_mis[i]   = 1'b0;
        end
        fd = $fopen("lsu_lq_patterns.txt", "r");
        if (fd == 0) stop_run("could not open the pattern file lsu_lq_patterns.txt");
        while (!$feof(fd)) begin
            if ($fgets(line, fd) > 0) begin
                cnt = $sscanf(line, "%s", cmd);
                if (cnt > 0 && cmd.getc(0) != 8'h23) begin
                    lines.push_back(line);
                    n_cmds++;
                end
            end
        end
        $fclose(fd);
        if (n_cmds == 0) stop_run("the pattern file lsu_lq_patterns.txt holds no commands");
        repeat (4) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;
        foreach (lines[k]) begin
            a = '0;
            b = '0;
            c = '0;
            d = '0;
            cnt = $sscanf(lines[k], "%s %h %h %h %h", cmd, a, b, c, d);
            @(negedge clk);
            check_outputs();
            alloc     = '0;
            upd       = '0;
            fill      = '0;
            store     = '0;
            flush     = 1'b0;
            retire_en = 1'b0;
            case (cmd)
                "ALLOC": begin
                    alloc.en   = 1'b1;
                    alloc.func = lsu_func_t'(a[`LQ_FUNC_WIDTH-1:0]);
                    alloc.tag  = b[`LQ_ROB_TAG_WIDTH-1:0];
                    alloc.addr = c;
                end
                "UPDATE": begin
                    upd.en         = 1'b1;
                    upd.select     = `LQ_DEPTH'(1) << a;
                    upd.retry      = b[3];
                    upd.replay     = b[2];
                    upd.mhq_retry  = b[1];
                    upd.mhq_replay = b[0];
                    upd.mhq_tag    = c[`LQ_MHQ_TAG_WIDTH-1:0];
                end
                "FILL": begin
                    fill.en  = 1'b1;
                    fill.tag = a[`LQ_MHQ_TAG_WIDTH-1:0];
                end
                "STORE": begin
                    store.en   = 1'b1;
                    store.func = lsu_func_t'(a[`LQ_FUNC_WIDTH-1:0]);
                    store.addr = b;
                end
                "STALL": stall = a[0];
                "RETIRE": begin
                    retire_en  = 1'b1;
                    retire_tag = a[`LQ_ROB_TAG_WIDTH-1:0];
                    f_chk_ret  = 1'b1;
                    f_ack      = b[0];
                    f_mis      = c[0];
                end
                "FLUSH": flush = 1'b1;
                "IDLE": begin
                    f_chk_rep = a[0];
                    f_rep_en  = b[0];
                    f_rep_tag = c;
                end
                default: stop_run($sformatf("unknown command %s in the pattern file", cmd));
            endcase
            #1;
            model_step();
            assert (full === e_full)
                else report_mismatch($sformatf("full %b, expected %b", full, e_full));
            if (cmd == "ALLOC") begin
                assert (full === d[0])
                    else report_mismatch($sformatf("full %b, pattern wants %b", full, d[0]));
            end
        end
        @(negedge clk);
        check_outputs();
        $display("TEST PASSED");
        $finish;
    end

    // Twenty cycles per command is far more than any command needs
    initial begin
        wait (n_rst === 1'b1);
        #(n_cmds * 20 * 10);
        stop_run("watchdog expired before the pattern file was done");
    end

endmodule

`default_nettype wire
